//--- list.f
l15_adapter_pkg.sv
l15_req_encoder.sv
l15_thread_tracker.sv
l15_resp_decoder.sv
l15_inval_fifo.sv
hpdc_l15_adapter.sv
tb_hpdc_l15_adapter.sv

//--- Makefile
# Verilator simulation of the cache to L1.5 adapter

VERILATOR ?= verilator
TOP       ?= tb_hpdc_l15_adapter
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

//--- tb_hpdc_l15_adapter.sv
// Testbench for the cache to L1.5 adapter
// Table-driven request checks, out of order thread returns and invalidation FIFO
`timescale 1ns/1ps
`default_nettype none

module tb_hpdc_l15_adapter;

    localparam int TIMEOUT = 100;   // Cycles allowed per wait

    typedef struct {
        l15_adapter_pkg::mem_cmd_e    cmd;
        l15_adapter_pkg::mem_amo_e    amo;
        int                           nbytes;   // Zero for loads
        logic [2:0]                   size;
        l15_adapter_pkg::l15_rqtype_e exp_type;
        logic [2:0]                   exp_size;
        l15_adapter_pkg::l15_amo_e    exp_amo;
    } req_vec_t;

    logic clk_i, rst_ni, req_valid_i, req_cacheable_i, l15_ack_i;
    logic l15_val_i, l15_threadid_i, l15_dinval_i, resp_ready_i, inval_ready_i;
    logic [l15_adapter_pkg::ID_WIDTH-1:0]    req_id_i, resp_id_o;
    logic [l15_adapter_pkg::PID_WIDTH-1:0]   req_pid_i, resp_pid_o;
    l15_adapter_pkg::mem_cmd_e               req_cmd_i;
    l15_adapter_pkg::mem_amo_e               req_amo_i;
    logic [l15_adapter_pkg::ADDR_WIDTH-1:0]  req_addr_i, l15_address_o;
    logic [l15_adapter_pkg::ADDR_WIDTH-1:0]  l15_inval_addr_i, inval_line_o;
    logic [2:0]                              req_size_i, l15_size_o;
    logic [l15_adapter_pkg::DWORD_WIDTH-1:0] req_wdata_i, l15_data_o;
    logic [l15_adapter_pkg::BE_WIDTH-1:0]    req_be_i;
    logic [l15_adapter_pkg::RDATA_WIDTH-1:0] l15_rdata_i, resp_rdata_o;
    l15_adapter_pkg::l15_rqtype_e            l15_rqtype_o;
    l15_adapter_pkg::l15_amo_e               l15_amo_op_o;
    l15_adapter_pkg::l15_rettype_e           l15_returntype_i;
    logic req_ready_o, l15_val_o, l15_nc_o, l15_threadid_o, l15_req_ack_o;
    logic resp_valid_o, resp_error_o, inval_valid_o;

    req_vec_t vecs[$];

    hpdc_l15_adapter uut (.*);

    always #5 clk_i = ~clk_i;

    task automatic mismatch_fail(input string sig, input string got, input string exp);
        $display("Mismatch at %0t ns: %s is %s, expected %s", $time, sig, got, exp);
        $display("** FAIL **");
        $fatal(1, "value check failed");
    endtask

    task automatic abort_on_timeout(input string sig);
        $display("Timed out after %0d cycles waiting for %s to go high", TIMEOUT, sig);
        $display("** FAIL **");
        $fatal(1, "wait timed out");
    endtask

    task automatic rqtype_ok(input string sig, input l15_adapter_pkg::l15_rqtype_e got,
                             input l15_adapter_pkg::l15_rqtype_e exp);
        if (got !== exp) mismatch_fail(sig, got.name(), exp.name());
    endtask
    task automatic amo_ok(input string sig, input l15_adapter_pkg::l15_amo_e got,
                          input l15_adapter_pkg::l15_amo_e exp);
        if (got !== exp) mismatch_fail(sig, got.name(), exp.name());
    endtask
    task automatic size_ok(input string sig, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) mismatch_fail(sig, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask
    task automatic addr_ok(input string sig, input logic [l15_adapter_pkg::ADDR_WIDTH-1:0] got,
                           input logic [l15_adapter_pkg::ADDR_WIDTH-1:0] exp);
        if (got !== exp) mismatch_fail(sig, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic dword_ok(input string sig, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) mismatch_fail(sig, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic rdata_ok(input string sig, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) mismatch_fail(sig, $sformatf("%h", got), $sformatf("%h", exp));
    endtask
    task automatic id_ok(input string sig, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) mismatch_fail(sig, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask
    task automatic port_ok(input string sig, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) mismatch_fail(sig, $sformatf("%0d", got), $sformatf("%0d", exp));
    endtask
    task automatic flag_ok(input string sig, input logic got, input logic exp);
        if (got !== exp) mismatch_fail(sig, $sformatf("%b", got), $sformatf("%b", exp));
    endtask

    // Polls at falling edges until the named output is high
    task automatic wait_high(input string sig);
        int   n;
        logic lvl;
        n = 0;
        forever begin
            @(negedge clk_i);
            if (sig == "req_ready_o") lvl = req_ready_o;
            else if (sig == "l15_req_ack_o") lvl = l15_req_ack_o;
            else lvl = inval_valid_o;
            if (lvl) break;
            n++;
            if (n > TIMEOUT) abort_on_timeout(sig);
        end
    endtask

    // Payload bytes from the offset, repeated every n bytes, then byte reversed
    function automatic logic [63:0] store_payload(input logic [63:0] src, input int off,
                                                  input int n);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = src[8*(off + ((7 - i) % n)) +: 8];
        end
        return r;
    endfunction

    function automatic logic [127:0] byte_swapped(input logic [127:0] d);
        logic [127:0] r;
        for (int i = 0; i < 16; i++) begin
            r[8*i +: 8] = d[8*(i ^ 7) +: 8];   // Reverse within each dword
        end
        return r;
    endfunction

    function automatic void push_vec(input l15_adapter_pkg::mem_cmd_e cmd,
                                     input l15_adapter_pkg::mem_amo_e amo, input int n,
                                     input logic [2:0] size,
                                     input l15_adapter_pkg::l15_rqtype_e et,
                                     input logic [2:0] es, input l15_adapter_pkg::l15_amo_e ea);
        vecs.push_back('{cmd, amo, n, size, et, es, ea});
    endfunction

    function automatic void atomic_entry(input l15_adapter_pkg::mem_amo_e amo, input int n,
                                         input logic [2:0] es,
                                         input l15_adapter_pkg::l15_amo_e ea);
        push_vec(l15_adapter_pkg::MEM_ATOMIC, amo, n, 3'd0, l15_adapter_pkg::ATOMIC_RQ, es, ea);
    endfunction

    task automatic fill_table();
        for (int k = 0; k < 4; k++) begin
            push_vec(l15_adapter_pkg::MEM_WRITE, l15_adapter_pkg::MEM_AMO_ADD, 1 << k, 3'd0,
                     l15_adapter_pkg::STORE_RQ, 3'(k), l15_adapter_pkg::L15_AMO_NONE);
        end
        atomic_entry(l15_adapter_pkg::MEM_AMO_ADD,  8, 3'd3, l15_adapter_pkg::L15_AMO_ADD);
        atomic_entry(l15_adapter_pkg::MEM_AMO_CLR,  4, 3'd2, l15_adapter_pkg::L15_AMO_AND);
        atomic_entry(l15_adapter_pkg::MEM_AMO_CLR,  8, 3'd3, l15_adapter_pkg::L15_AMO_AND);
        atomic_entry(l15_adapter_pkg::MEM_AMO_SET,  4, 3'd2, l15_adapter_pkg::L15_AMO_OR);
        atomic_entry(l15_adapter_pkg::MEM_AMO_EOR,  8, 3'd3, l15_adapter_pkg::L15_AMO_XOR);
        atomic_entry(l15_adapter_pkg::MEM_AMO_SMAX, 4, 3'd2, l15_adapter_pkg::L15_AMO_MAX);
        atomic_entry(l15_adapter_pkg::MEM_AMO_SMIN, 8, 3'd3, l15_adapter_pkg::L15_AMO_MIN);
        atomic_entry(l15_adapter_pkg::MEM_AMO_UMAX, 4, 3'd2, l15_adapter_pkg::L15_AMO_MAXU);
        atomic_entry(l15_adapter_pkg::MEM_AMO_UMIN, 8, 3'd3, l15_adapter_pkg::L15_AMO_MINU);
        atomic_entry(l15_adapter_pkg::MEM_AMO_SWAP, 4, 3'd2, l15_adapter_pkg::L15_AMO_SWAP);
        atomic_entry(l15_adapter_pkg::MEM_AMO_LDEX, 8, 3'd3, l15_adapter_pkg::L15_AMO_LR);
        atomic_entry(l15_adapter_pkg::MEM_AMO_STEX, 8, 3'd3, l15_adapter_pkg::L15_AMO_SC);
        for (int s = 0; s < 5; s++) begin
            push_vec(l15_adapter_pkg::MEM_READ, l15_adapter_pkg::MEM_AMO_ADD, 0, 3'(s),
                     l15_adapter_pkg::LOAD_RQ, (s == 4) ? 3'd7 : 3'(s),
                     l15_adapter_pkg::L15_AMO_NONE);
        end
    endtask

    initial begin
        req_vec_t     v;
        int           off;
        int           t;
        logic [39:0]  addr;
        logic [63:0]  wdata;
        logic [63:0]  src;
        logic [127:0] rdata;
        logic [3:0]   tag_id [2];
        logic [2:0]   tag_pid [2];
        logic [39:0]  lines [$];
        void'($urandom(48081));
        clk_i = 1'b0;
        rst_ni = 1'b0;
        req_valid_i = 1'b0;
        req_id_i = '0;
        req_pid_i = '0;
        req_cmd_i = l15_adapter_pkg::MEM_READ;
        req_amo_i = l15_adapter_pkg::MEM_AMO_ADD;
        req_addr_i = '0;
        req_size_i = '0;
        req_cacheable_i = 1'b1;
        req_wdata_i = '0;
        req_be_i = 8'h01;
        l15_ack_i = 1'b1;
        l15_val_i = 1'b0;
        l15_returntype_i = l15_adapter_pkg::LOAD_RET;
        l15_threadid_i = 1'b0;
        l15_rdata_i = '0;
        l15_dinval_i = 1'b0;
        l15_inval_addr_i = '0;
        resp_ready_i = 1'b0;
        inval_ready_i = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        flag_ok("inval_valid_o", inval_valid_o, 1'b0);
        flag_ok("resp_valid_o", resp_valid_o, 1'b0);

        // Request translation from the table
        fill_table();
        foreach (vecs[i]) begin
            v = vecs[i];
            addr = 40'({$urandom(), $urandom()});
            wdata = {$urandom(), $urandom()};
            off = (v.nbytes > 0) ? int'($urandom() % 32'(8 / v.nbytes)) * v.nbytes : 0;
            src = (v.amo == l15_adapter_pkg::MEM_AMO_CLR &&
                   v.cmd == l15_adapter_pkg::MEM_ATOMIC) ? ~wdata : wdata;
            @(posedge clk_i);
            #1;
            req_cmd_i = v.cmd;
            req_amo_i = v.amo;
            req_addr_i = addr;
            req_size_i = v.size;
            req_wdata_i = wdata;
            req_cacheable_i = 1'($urandom());
            req_be_i = (v.nbytes > 0) ? 8'(((1 << v.nbytes) - 1) << off) : 8'h01;
            @(negedge clk_i);
            rqtype_ok("l15_rqtype_o", l15_rqtype_o, v.exp_type);
            size_ok("l15_size_o", l15_size_o, v.exp_size);
            flag_ok("l15_nc_o", l15_nc_o, ~req_cacheable_i);
            if (v.nbytes > 0) begin
                addr_ok("l15_address_o", l15_address_o, {addr[39:3], 3'(off)});
                dword_ok("l15_data_o", l15_data_o, store_payload(src, off, v.nbytes));
            end else begin
                addr_ok("l15_address_o", l15_address_o, addr);
            end
            if (v.cmd == l15_adapter_pkg::MEM_ATOMIC) begin
                amo_ok("l15_amo_op_o", l15_amo_op_o, v.exp_amo);
            end
        end

        // Two loads in flight, a third must stall
        tag_id = '{4'd3, 4'd9};
        tag_pid = '{3'd2, 3'd6};
        for (int k = 0; k < 2; k++) begin
            @(posedge clk_i);
            #1;
            req_valid_i = 1'b1;
            req_cmd_i = l15_adapter_pkg::MEM_READ;
            req_id_i = tag_id[k];
            req_pid_i = tag_pid[k];
            wait_high("req_ready_o");
            flag_ok("l15_val_o", l15_val_o, 1'b1);
            flag_ok("l15_threadid_o", l15_threadid_o, 1'(k));
        end
        @(posedge clk_i);
        #1;
        req_id_i = 4'd12;
        @(negedge clk_i);
        flag_ok("req_ready_o", req_ready_o, 1'b0);
        flag_ok("l15_val_o", l15_val_o, 1'b0);
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;

        // Error return held back while the cache is not ready
        l15_val_i = 1'b1;
        l15_returntype_i = l15_adapter_pkg::ERR_RET;
        @(negedge clk_i);
        flag_ok("resp_error_o", resp_error_o, 1'b1);
        flag_ok("l15_req_ack_o", l15_req_ack_o, 1'b0);
        @(posedge clk_i);
        #1;

        // Out of order returns, the second one atomic
        for (int k = 0; k < 2; k++) begin
            t = 1 - k;
            rdata = {$urandom(), $urandom(), $urandom(), $urandom()};
            l15_val_i = 1'b1;
            l15_threadid_i = 1'(t);
            l15_returntype_i = (k == 1) ? l15_adapter_pkg::ATOMIC_RES : l15_adapter_pkg::LOAD_RET;
            l15_rdata_i = rdata;
            resp_ready_i = 1'b1;
            wait_high("l15_req_ack_o");
            flag_ok("resp_valid_o", resp_valid_o, 1'b1);
            flag_ok("resp_error_o", resp_error_o, 1'b0);
            id_ok("resp_id_o", resp_id_o, tag_id[t]);
            port_ok("resp_pid_o", resp_pid_o, (k == 1) ? 3'd5 : tag_pid[t]);   // Atomics to port 5
            rdata_ok("resp_rdata_o", resp_rdata_o, byte_swapped(rdata));
            @(posedge clk_i);
            #1;
            l15_val_i = 1'b0;
        end

        // Evictions fill the FIFO, the sixth is held off
        resp_ready_i = 1'b0;
        for (int k = 0; k < 6; k++) begin
            addr = 40'({$urandom(), $urandom()});
            l15_val_i = 1'b1;
            l15_returntype_i = l15_adapter_pkg::EVICT_REQ;
            l15_dinval_i = 1'b1;
            l15_inval_addr_i = addr;
            if (k < 5) begin
                wait_high("l15_req_ack_o");
                flag_ok("resp_valid_o", resp_valid_o, 1'b0);
                lines.push_back({addr[39:4], 4'h0});
            end else begin
                repeat (3) begin
                    @(negedge clk_i);
                    flag_ok("l15_req_ack_o", l15_req_ack_o, 1'b0);
                end
            end
            @(posedge clk_i);
            #1;
            l15_val_i = 1'b0;
            if (k == 0) begin
                wait_high("inval_valid_o");
                addr_ok("inval_line_o", inval_line_o, lines[0]);
                @(posedge clk_i);
                #1;
            end
        end
        l15_dinval_i = 1'b0;

        // Drain in order
        inval_ready_i = 1'b1;
        foreach (lines[i]) begin
            wait_high("inval_valid_o");
            addr_ok("inval_line_o", inval_line_o, lines[i]);
            @(posedge clk_i);
            #1;
        end
        @(negedge clk_i);
        flag_ok("inval_valid_o", inval_valid_o, 1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- hpdc_l15_adapter.sv
// Cache to L1.5 adapter top level
// Connects request encoder, thread tracker, return decoder and inval FIFO
`timescale 1ns/1ps
`default_nettype none

module hpdc_l15_adapter (
    input  wire                                      clk_i,
    input  wire                                      rst_ni,
    input  wire                                      req_valid_i,
    output logic                                     req_ready_o,
    input  wire [l15_adapter_pkg::ID_WIDTH-1:0]      req_id_i,
    input  wire [l15_adapter_pkg::PID_WIDTH-1:0]     req_pid_i,
    input  wire l15_adapter_pkg::mem_cmd_e           req_cmd_i,
    input  wire l15_adapter_pkg::mem_amo_e           req_amo_i,
    input  wire [l15_adapter_pkg::ADDR_WIDTH-1:0]    req_addr_i,
    input  wire [2:0]                                req_size_i,
    input  wire                                      req_cacheable_i,
    input  wire [l15_adapter_pkg::DWORD_WIDTH-1:0]   req_wdata_i,
    input  wire [l15_adapter_pkg::BE_WIDTH-1:0]      req_be_i,
    input  wire                                      l15_ack_i,
    output logic                                     l15_val_o,
    output l15_adapter_pkg::l15_rqtype_e             l15_rqtype_o,
    output logic                                     l15_nc_o,
    output logic [2:0]                               l15_size_o,
    output logic                                     l15_threadid_o,
    output logic [l15_adapter_pkg::ADDR_WIDTH-1:0]   l15_address_o,
    output logic [l15_adapter_pkg::DWORD_WIDTH-1:0]  l15_data_o,
    output l15_adapter_pkg::l15_amo_e                l15_amo_op_o,
    input  wire                                      l15_val_i,
    input  wire l15_adapter_pkg::l15_rettype_e       l15_returntype_i,
    input  wire                                      l15_threadid_i,
    input  wire [l15_adapter_pkg::RDATA_WIDTH-1:0]   l15_rdata_i,
    input  wire                                      l15_dinval_i,
    input  wire [l15_adapter_pkg::ADDR_WIDTH-1:0]    l15_inval_addr_i,
    output logic                                     l15_req_ack_o,
    input  wire                                      resp_ready_i,
    output logic                                     resp_valid_o,
    output logic [l15_adapter_pkg::ID_WIDTH-1:0]     resp_id_o,
    output logic [l15_adapter_pkg::PID_WIDTH-1:0]    resp_pid_o,
    output logic [l15_adapter_pkg::RDATA_WIDTH-1:0]  resp_rdata_o,
    output logic                                     resp_error_o,
    input  wire                                      inval_ready_i,
    output logic                                     inval_valid_o,
    output logic [l15_adapter_pkg::ADDR_WIDTH-1:0]   inval_line_o
);

    logic                                   resp_take;
    logic [l15_adapter_pkg::PID_WIDTH-1:0]  slot_pid;
    logic                                   fifo_wok;
    logic                                   fifo_write;
    logic [l15_adapter_pkg::ADDR_WIDTH-1:0] fifo_line;

    l15_req_encoder u_enc (
        .req_cmd_i, .req_amo_i, .req_addr_i, .req_size_i, .req_cacheable_i,
        .req_wdata_i, .req_be_i,
        .l15_rqtype_o, .l15_nc_o, .l15_size_o, .l15_address_o, .l15_data_o, .l15_amo_op_o
    );

    l15_thread_tracker u_trk (
        .clk_i, .rst_ni, .req_valid_i, .req_id_i, .req_pid_i, .l15_ack_i,
        .resp_take_i (resp_take),
        .l15_threadid_i,
        .req_ready_o, .l15_val_o, .l15_threadid_o, .resp_id_o,
        .resp_pid_o  (slot_pid)
    );

    l15_resp_decoder u_dec (
        .l15_val_i, .l15_returntype_i, .l15_rdata_i, .l15_dinval_i, .l15_inval_addr_i,
        .resp_ready_i,
        .fifo_wok_i   (fifo_wok),
        .slot_pid_i   (slot_pid),
        .l15_req_ack_o,
        .resp_take_o  (resp_take),
        .resp_valid_o, .resp_pid_o, .resp_rdata_o, .resp_error_o,
        .fifo_write_o (fifo_write),
        .fifo_line_o  (fifo_line)
    );

    l15_inval_fifo #(
        .DEPTH (l15_adapter_pkg::INVAL_FIFO_DEPTH)
    ) u_fifo (
        .clk_i, .rst_ni,
        .write_i (fifo_write),
        .line_i  (fifo_line),
        .read_i  (inval_ready_i),
        .wok_o   (fifo_wok),
        .rok_o   (inval_valid_o),   // Pending invalidation
        .line_o  (inval_line_o)
    );

endmodule

`default_nettype wire

//--- l15_inval_fifo.sv
// Data-cache invalidation FIFO
// Register storage of line addresses with pointer and count tracking
`timescale 1ns/1ps
`default_nettype none

module l15_inval_fifo #(
    parameter int DEPTH = 5
) (
    input  wire                                    clk_i,
    input  wire                                    rst_ni,
    input  wire                                    write_i,
    input  wire [l15_adapter_pkg::ADDR_WIDTH-1:0]  line_i,
    input  wire                                    read_i,
    output logic                                   wok_o,
    output logic                                   rok_o,
    output logic [l15_adapter_pkg::ADDR_WIDTH-1:0] line_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [l15_adapter_pkg::ADDR_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_read;

    assign wok_o   = (count_q != CNT_W'(DEPTH));
    assign rok_o   = (count_q != '0);
    assign line_o  = mem[rd_ptr_q];
    assign do_read = read_i & rok_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (write_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
            if (do_read) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
            count_q <= count_q + CNT_W'(write_i) - CNT_W'(do_read);
        end
    end

    always_ff @(posedge clk_i) begin
        if (write_i) mem[wr_ptr_q] <= line_i;
    end

    // Decoder must hold writes off while full
    assert property (@(posedge clk_i) disable iff (!rst_ni) write_i |-> wok_o)
        else $error("write into full invalidation FIFO");

endmodule

`default_nettype wire

//--- l15_resp_decoder.sv
// L1.5 return decoder
// Ack and valid gating, data swap, port routing and invalidation decode
`timescale 1ns/1ps
`default_nettype none

module l15_resp_decoder (
    input  wire                                      l15_val_i,
    input  wire l15_adapter_pkg::l15_rettype_e       l15_returntype_i,
    input  wire [l15_adapter_pkg::RDATA_WIDTH-1:0]   l15_rdata_i,
    input  wire                                      l15_dinval_i,
    input  wire [l15_adapter_pkg::ADDR_WIDTH-1:0]    l15_inval_addr_i,
    input  wire                                      resp_ready_i,
    input  wire                                      fifo_wok_i,
    input  wire [l15_adapter_pkg::PID_WIDTH-1:0]     slot_pid_i,
    output logic                                     l15_req_ack_o,
    output logic                                     resp_take_o,
    output logic                                     resp_valid_o,
    output logic [l15_adapter_pkg::PID_WIDTH-1:0]    resp_pid_o,
    output logic [l15_adapter_pkg::RDATA_WIDTH-1:0]  resp_rdata_o,
    output logic                                     resp_error_o,
    output logic                                     fifo_write_o,
    output logic [l15_adapter_pkg::ADDR_WIDTH-1:0]   fifo_line_o
);

    logic only_inval;
    logic space_ok;

    assign only_inval = (l15_returntype_i == l15_adapter_pkg::EVICT_REQ);
    assign space_ok   = ~l15_dinval_i | fifo_wok_i;   // FIFO room when an inval rides along

    assign l15_req_ack_o = l15_val_i & space_ok & (only_inval | resp_ready_i);
    assign resp_valid_o  = l15_val_i & space_ok & ~only_inval;
    assign resp_take_o   = resp_valid_o & resp_ready_i;

    // Only write once the return is acked, else it is presented again
    assign fifo_write_o = l15_req_ack_o & l15_dinval_i;
    assign fifo_line_o  = {l15_inval_addr_i[l15_adapter_pkg::ADDR_WIDTH-1:
                                            l15_adapter_pkg::LINE_OFFSET_WIDTH],
                           {l15_adapter_pkg::LINE_OFFSET_WIDTH{1'b0}}};

    assign resp_rdata_o = {l15_adapter_pkg::bswap64(l15_rdata_i[127:64]),
                           l15_adapter_pkg::bswap64(l15_rdata_i[63:0])};

    assign resp_pid_o   = (l15_returntype_i == l15_adapter_pkg::ATOMIC_RES) ?
                          l15_adapter_pkg::PID_WIDTH'(l15_adapter_pkg::AMO_PORT_ID) : slot_pid_i;
    assign resp_error_o = (l15_returntype_i == l15_adapter_pkg::ERR_RET);

endmodule

`default_nettype wire

//--- l15_thread_tracker.sv
// L1.5 thread id tracker
// Two-slot FSM recording requester id and port per L1.5 thread id
`timescale 1ns/1ps
`default_nettype none

module l15_thread_tracker (
    input  wire                                    clk_i,
    input  wire                                    rst_ni,
    input  wire                                    req_valid_i,
    input  wire [l15_adapter_pkg::ID_WIDTH-1:0]    req_id_i,
    input  wire [l15_adapter_pkg::PID_WIDTH-1:0]   req_pid_i,
    input  wire                                    l15_ack_i,
    input  wire                                    resp_take_i,
    input  wire                                    l15_threadid_i,
    output logic                                   req_ready_o,
    output logic                                   l15_val_o,
    output logic                                   l15_threadid_o,
    output logic [l15_adapter_pkg::ID_WIDTH-1:0]   resp_id_o,
    output logic [l15_adapter_pkg::PID_WIDTH-1:0]  resp_pid_o
);

    l15_adapter_pkg::slot_state_e state_q, state_d;
    logic [l15_adapter_pkg::ID_WIDTH-1:0]  id_q  [2];
    logic [l15_adapter_pkg::PID_WIDTH-1:0] pid_q [2];
    logic slot_free;
    logic req_take;

    assign slot_free      = (state_q != l15_adapter_pkg::LOCKED);
    assign req_ready_o    = l15_ack_i & slot_free;
    assign l15_val_o      = req_valid_i & slot_free;
    assign req_take       = req_valid_i & req_ready_o;
    assign l15_threadid_o = (state_q == l15_adapter_pkg::FREE_T1);

    assign resp_id_o  = id_q[l15_threadid_i];
    assign resp_pid_o = pid_q[l15_threadid_i];

    always_comb begin
        state_d = state_q;
        case (state_q)
            l15_adapter_pkg::FREE_BOTH: begin
                if (req_take) state_d = l15_adapter_pkg::FREE_T1;
            end
            l15_adapter_pkg::FREE_T0: begin   // T1 busy
                if (req_take && resp_take_i) state_d = l15_adapter_pkg::FREE_T1;
                else if (resp_take_i)        state_d = l15_adapter_pkg::FREE_BOTH;
                else if (req_take)           state_d = l15_adapter_pkg::LOCKED;
            end
            l15_adapter_pkg::FREE_T1: begin   // T0 busy
                if (req_take && resp_take_i) state_d = l15_adapter_pkg::FREE_T0;
                else if (resp_take_i)        state_d = l15_adapter_pkg::FREE_BOTH;
                else if (req_take)           state_d = l15_adapter_pkg::LOCKED;
            end
            default: begin
                if (resp_take_i) begin
                    state_d = l15_threadid_i ? l15_adapter_pkg::FREE_T1
                                             : l15_adapter_pkg::FREE_T0;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= l15_adapter_pkg::FREE_BOTH;
        end else begin
            state_q <= state_d;
        end
    end

    // Tables written on the issuing slot
    always_ff @(posedge clk_i) begin
        if (req_take) begin
            id_q[l15_threadid_o]  <= req_id_i;
            pid_q[l15_threadid_o] <= req_pid_i;
        end
    end

    // A taken return must name a slot that holds a request
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_take_i |-> (l15_threadid_i ? (state_q inside {l15_adapter_pkg::FREE_T0,
                                                           l15_adapter_pkg::LOCKED})
                                        : (state_q inside {l15_adapter_pkg::FREE_T1,
                                                           l15_adapter_pkg::LOCKED})))
        else $error("response names a free thread id %0d", l15_threadid_i);

endmodule

`default_nettype wire

//--- l15_req_encoder.sv
// L1.5 request encoder
// Derives type, size, aligned address, replicated swapped data and AMO opcode
`timescale 1ns/1ps
`default_nettype none

module l15_req_encoder (
    input  wire l15_adapter_pkg::mem_cmd_e                     req_cmd_i,
    input  wire l15_adapter_pkg::mem_amo_e                     req_amo_i,
    input  wire [l15_adapter_pkg::ADDR_WIDTH-1:0]              req_addr_i,
    input  wire [2:0]                                          req_size_i,
    input  wire                                                req_cacheable_i,
    input  wire [l15_adapter_pkg::DWORD_WIDTH-1:0]             req_wdata_i,
    input  wire [l15_adapter_pkg::BE_WIDTH-1:0]                req_be_i,
    output l15_adapter_pkg::l15_rqtype_e                       l15_rqtype_o,
    output logic                                               l15_nc_o,
    output logic [2:0]                                         l15_size_o,
    output logic [l15_adapter_pkg::ADDR_WIDTH-1:0]             l15_address_o,
    output logic [l15_adapter_pkg::DWORD_WIDTH-1:0]            l15_data_o,
    output l15_adapter_pkg::l15_amo_e                          l15_amo_op_o
);

    logic                                     is_st_amo;
    logic [3:0]                               be_cnt;
    logic [2:0]                               offset;
    logic [2:0]                               st_size;
    logic [l15_adapter_pkg::DWORD_WIDTH-1:0]  wdata;
    logic [l15_adapter_pkg::DWORD_WIDTH-1:0]  shifted;
    logic [l15_adapter_pkg::DWORD_WIDTH-1:0]  rep;

    assign is_st_amo = (req_cmd_i != l15_adapter_pkg::MEM_READ);
    assign be_cnt    = 4'($countones(req_be_i));
    assign l15_nc_o  = ~req_cacheable_i;

    // CLR is sent as AND with the inverted operand
    assign wdata = (req_cmd_i == l15_adapter_pkg::MEM_ATOMIC &&
                    req_amo_i == l15_adapter_pkg::MEM_AMO_CLR) ? ~req_wdata_i : req_wdata_i;

    always_comb begin
        l15_rqtype_o = l15_adapter_pkg::ATOMIC_RQ;
        if (req_cmd_i == l15_adapter_pkg::MEM_READ) begin
            l15_rqtype_o = l15_adapter_pkg::LOAD_RQ;
        end else if (req_cmd_i == l15_adapter_pkg::MEM_WRITE) begin
            l15_rqtype_o = l15_adapter_pkg::STORE_RQ;
        end
    end

    // Lowest set byte enable gives the offset
    always_comb begin
        offset = '0;
        for (int i = l15_adapter_pkg::BE_WIDTH-1; i >= 0; i--) begin
            if (req_be_i[i]) offset = i[2:0];
        end
    end

    always_comb begin
        case (be_cnt)
            4'd1:    st_size = l15_adapter_pkg::SIZE_1B;
            4'd2:    st_size = l15_adapter_pkg::SIZE_2B;
            4'd4:    st_size = l15_adapter_pkg::SIZE_4B;
            default: st_size = l15_adapter_pkg::SIZE_8B;
        endcase
    end

    assign shifted = wdata >> {offset, 3'b000};

    // Replicate the payload over the whole dword
    always_comb begin
        case (st_size)
            l15_adapter_pkg::SIZE_1B: rep = {8{shifted[7:0]}};
            l15_adapter_pkg::SIZE_2B: rep = {4{shifted[15:0]}};
            l15_adapter_pkg::SIZE_4B: rep = {2{shifted[31:0]}};
            default:                  rep = shifted;
        endcase
    end

    assign l15_size_o    = is_st_amo ? st_size :
                           (req_size_i == 3'd4) ? l15_adapter_pkg::SIZE_LINE : req_size_i;
    assign l15_address_o = is_st_amo ? {req_addr_i[l15_adapter_pkg::ADDR_WIDTH-1:3], offset}
                                     : req_addr_i;
    assign l15_data_o    = l15_adapter_pkg::bswap64(is_st_amo ? rep : wdata);

    always_comb begin
        case (req_amo_i)
            l15_adapter_pkg::MEM_AMO_ADD:  l15_amo_op_o = l15_adapter_pkg::L15_AMO_ADD;
            l15_adapter_pkg::MEM_AMO_CLR:  l15_amo_op_o = l15_adapter_pkg::L15_AMO_AND;
            l15_adapter_pkg::MEM_AMO_SET:  l15_amo_op_o = l15_adapter_pkg::L15_AMO_OR;
            l15_adapter_pkg::MEM_AMO_EOR:  l15_amo_op_o = l15_adapter_pkg::L15_AMO_XOR;
            l15_adapter_pkg::MEM_AMO_SMAX: l15_amo_op_o = l15_adapter_pkg::L15_AMO_MAX;
            l15_adapter_pkg::MEM_AMO_SMIN: l15_amo_op_o = l15_adapter_pkg::L15_AMO_MIN;
            l15_adapter_pkg::MEM_AMO_UMAX: l15_amo_op_o = l15_adapter_pkg::L15_AMO_MAXU;
            l15_adapter_pkg::MEM_AMO_UMIN: l15_amo_op_o = l15_adapter_pkg::L15_AMO_MINU;
            l15_adapter_pkg::MEM_AMO_SWAP: l15_amo_op_o = l15_adapter_pkg::L15_AMO_SWAP;
            l15_adapter_pkg::MEM_AMO_LDEX: l15_amo_op_o = l15_adapter_pkg::L15_AMO_LR;
            l15_adapter_pkg::MEM_AMO_STEX: l15_amo_op_o = l15_adapter_pkg::L15_AMO_SC;
            default:                       l15_amo_op_o = l15_adapter_pkg::L15_AMO_NONE;
        endcase
    end

    // Store and AMO enables must cover 1, 2, 4 or 8 bytes
    always_comb begin
        assert final (!is_st_amo || $isunknown(req_be_i) || $onehot(be_cnt))
            else $error("byte enable count %0d is not a power of two", be_cnt);
    end

endmodule

`default_nettype wire

//--- l15_adapter_pkg.sv
// L1.5 adapter shared definitions
// Widths, size codes, opcode enums and the byte swap helper
`default_nettype none

package l15_adapter_pkg;

    localparam int ADDR_WIDTH        = 40;
    localparam int DWORD_WIDTH       = 64;
    localparam int BE_WIDTH          = 8;
    localparam int RDATA_WIDTH       = 128;
    localparam int ID_WIDTH          = 4;
    localparam int PID_WIDTH         = 3;
    localparam int LINE_OFFSET_WIDTH = 4;   // 16B line
    localparam int AMO_PORT_ID       = 5;
    localparam int INVAL_FIFO_DEPTH  = 5;

    // L1.5 size codes
    localparam logic [2:0] SIZE_1B   = 3'd0;
    localparam logic [2:0] SIZE_2B   = 3'd1;
    localparam logic [2:0] SIZE_4B   = 3'd2;
    localparam logic [2:0] SIZE_8B   = 3'd3;
    localparam logic [2:0] SIZE_LINE = 3'd7;

    typedef enum logic [1:0] {
        MEM_READ,
        MEM_WRITE,
        MEM_ATOMIC
    } mem_cmd_e;

    typedef enum logic [3:0] {
        MEM_AMO_ADD, MEM_AMO_CLR, MEM_AMO_SET, MEM_AMO_EOR,
        MEM_AMO_SMAX, MEM_AMO_SMIN, MEM_AMO_UMAX, MEM_AMO_UMIN,
        MEM_AMO_SWAP, MEM_AMO_LDEX, MEM_AMO_STEX
    } mem_amo_e;

    typedef enum logic [3:0] {
        L15_AMO_NONE, L15_AMO_ADD, L15_AMO_AND, L15_AMO_OR,
        L15_AMO_XOR, L15_AMO_MAX, L15_AMO_MIN, L15_AMO_MAXU,
        L15_AMO_MINU, L15_AMO_SWAP, L15_AMO_LR, L15_AMO_SC
    } l15_amo_e;

    typedef enum logic [1:0] {
        LOAD_RQ,
        STORE_RQ,
        ATOMIC_RQ
    } l15_rqtype_e;

    typedef enum logic [2:0] {
        LOAD_RET,
        ST_ACK,
        ATOMIC_RES,
        EVICT_REQ,  // Invalidation only
        ERR_RET
    } l15_rettype_e;

    typedef enum logic [1:0] {
        FREE_BOTH,
        FREE_T0,
        FREE_T1,
        LOCKED
    } slot_state_e;

    // Reverse byte order of one dword
    function automatic logic [DWORD_WIDTH-1:0] bswap64(input logic [DWORD_WIDTH-1:0] d);
        logic [DWORD_WIDTH-1:0] r;
        for (int i = 0; i < BE_WIDTH; i++) begin
            r[8*i +: 8] = d[8*(BE_WIDTH-1-i) +: 8];
        end
        return r;
    endfunction

endpackage

`default_nettype wire
